// File: design/keccak_pkg.sv
package keccak_pkg;

  localparam int LANE_W     = 64;
  localparam int NUM_LANES  = 25;
  localparam int STATE_W    = LANE_W * NUM_LANES;  // 1600
  localparam int NUM_ROUNDS = 24;

  typedef logic [LANE_W-1:0]  lane_t;
  typedef logic [STATE_W-1:0] state_t;   // lane 5*y+x sits at bit 64*(5*y+x)
  typedef logic [4:0]         round_t;
  typedef logic [7:0]         rc_lfsr_t;

  // x^8 + x^6 + x^5 + x^4 + 1 with bit 0 as the output end
  localparam rc_lfsr_t RC_POLY = 8'h71;

  // left rotation applied to lane (x,y) by rho
  function automatic int rho_offset(input int x, input int y);
    int rot;
    case (5 * y + x)
      0:       rot = 0;
      1:       rot = 1;
      2:       rot = 62;
      3:       rot = 28;
      4:       rot = 27;
      5:       rot = 36;
      6:       rot = 44;
      7:       rot = 6;
      8:       rot = 55;
      9:       rot = 20;
      10:      rot = 3;
      11:      rot = 10;
      12:      rot = 43;
      13:      rot = 25;
      14:      rot = 39;
      15:      rot = 41;
      16:      rot = 45;
      17:      rot = 15;
      18:      rot = 21;
      19:      rot = 8;
      20:      rot = 18;
      21:      rot = 2;
      22:      rot = 61;
      23:      rot = 56;
      24:      rot = 14;
      default: rot = 0;
    endcase
    return rot;
  endfunction

endpackage

// File: design/shake_pkg.sv
package shake_pkg;

  localparam int WORD_W     = 64;
  localparam int RATE_WORDS = 21;
  localparam int RATE_W     = RATE_WORDS * WORD_W;  // 1344 for SHAKE128

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [3:0]        nbytes_t;    // 0 to 8 on the last word only
  typedef logic [4:0]        word_idx_t;
  typedef logic [RATE_W-1:0] rate_t;

  // SHAKE domain bits plus the first pad bit
  localparam logic [7:0] DOMAIN_PAD = 8'h1F;
  // closing pad bit at the top of rate word RATE_WORDS-1
  localparam word_t      FINAL_PAD  = {1'b1, {(WORD_W-1){1'b0}}};

  typedef enum logic {
    BLK_START,      // zero state, then load the block
    BLK_CONTINUE    // xor the block into the kept state
  } blk_op_e;

  typedef enum logic [1:0] {
    ABS_FILL,
    ABS_PAD_BLOCK,
    ABS_SEND
  } absorb_state_e;

  typedef enum logic [1:0] {
    PERM_IDLE,
    PERM_RUN,
    PERM_HOLD
  } perm_state_e;

endpackage

// File: design/keccak_round.sv
`timescale 1ns/1ps

module keccak_round (
  input  keccak_pkg::state_t state_in,
  input  logic [6:0]         rc_bits,
  output keccak_pkg::state_t state_out
);
  import keccak_pkg::*;

  lane_t a [NUM_LANES];   // input lanes
  lane_t c [5];           // column parities
  lane_t d [5];
  lane_t b [NUM_LANES];   // after theta, rho and pi
  lane_t e [NUM_LANES];   // after chi
  lane_t rc_lane;

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_unpack
    assign a[i] = state_in[i*LANE_W +: LANE_W];
  end

  ////////////////////////////////////////////////////////////////////////////
  // theta
  for (genvar x = 0; x < 5; x++) begin : g_theta
    assign c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
    assign d[x] = c[(x+4)%5] ^ {c[(x+1)%5][LANE_W-2:0], c[(x+1)%5][LANE_W-1]};
  end

  ////////////////////////////////////////////////////////////////////////////
  // rho, pi and chi
  for (genvar y = 0; y < 5; y++) begin : g_row
    for (genvar x = 0; x < 5; x++) begin : g_col
      // lane (x,y) takes the rotated lane ((x+3y)%5, x)
      localparam int SX  = (x + 3 * y) % 5;
      localparam int ROT = rho_offset(SX, x);
      lane_t t;

      assign t = a[5*x + SX] ^ d[SX];
      assign b[5*y + x] = (t << ROT) | (t >> ((LANE_W - ROT) % LANE_W));
      assign e[5*y + x] = b[5*y + x] ^ (~b[5*y + (x+1)%5] & b[5*y + (x+2)%5]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // iota
  always_comb begin
    rc_lane = '0;
    for (int i = 0; i < 7; i++) begin
      rc_lane[(1 << i) - 1] = rc_bits[i];   // bit positions 0,1,3,7,15,31,63
    end
  end

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_pack
    if (i == 0) begin : g_iota
      assign state_out[i*LANE_W +: LANE_W] = e[i] ^ rc_lane;
    end else begin : g_pass
      assign state_out[i*LANE_W +: LANE_W] = e[i];
    end
  end

endmodule

// File: design/keccak_perm.sv
`timescale 1ns/1ps

module keccak_perm (
  input  logic               clk,
  input  logic               arst_n,
  input  shake_pkg::rate_t   blk_data,
  input  shake_pkg::blk_op_e blk_op,
  input  logic               blk_final,
  input  logic               blk_valid,
  output logic               blk_ready,
  output shake_pkg::rate_t   sq_data,
  output logic               sq_valid,
  input  logic               sq_ready
);
  import keccak_pkg::*;
  import shake_pkg::*;

  perm_state_e state_q;
  perm_state_e state_d;
  state_t      keccak_q;      // sponge state
  state_t      mixed;
  state_t      round_in;
  state_t      round_out;
  round_t      round_q;       // round applied in the current RUN cycle
  rc_lfsr_t    lfsr_q;
  rc_lfsr_t    lfsr_seed;
  rc_lfsr_t    lfsr_next;
  logic [6:0]  rc_bits;
  logic        final_q;
  logic        blk_fire;
  logic        advance;
  logic        last_round;

  assign blk_ready  = (state_q == PERM_IDLE);
  assign blk_fire   = blk_valid && blk_ready;
  assign advance    = blk_fire || (state_q == PERM_RUN);
  assign last_round = (state_q == PERM_RUN) && (round_q == round_t'(NUM_ROUNDS - 1));
  assign sq_valid   = (state_q == PERM_HOLD);
  assign sq_data    = keccak_q[RATE_W-1:0];

  always_comb begin
    if (blk_op == BLK_START) begin
      mixed = {{(STATE_W-RATE_W){1'b0}}, blk_data};
    end else begin
      mixed = {keccak_q[STATE_W-1:RATE_W], keccak_q[RATE_W-1:0] ^ blk_data};
    end
  end

  // round 0 runs in the transfer cycle on the freshly mixed block
  assign round_in  = (state_q == PERM_RUN) ? keccak_q : mixed;
  assign lfsr_seed = (state_q == PERM_RUN) ? lfsr_q : rc_lfsr_t'(1);

  // seven lfsr steps per round
  always_comb begin
    lfsr_next = lfsr_seed;
    for (int i = 0; i < 7; i++) begin
      rc_bits[i] = lfsr_next[0];
      lfsr_next  = {lfsr_next[6:0], 1'b0} ^ (RC_POLY & {8{lfsr_next[7]}});
    end
  end

  keccak_round i_round (
    .state_in  (round_in),
    .rc_bits   (rc_bits),
    .state_out (round_out)
  );

  always_comb begin
    state_d = state_q;
    case (state_q)
      PERM_IDLE: if (blk_fire) state_d = PERM_RUN;
      PERM_RUN:  if (last_round) state_d = final_q ? PERM_HOLD : PERM_IDLE;
      PERM_HOLD: if (sq_ready) state_d = PERM_IDLE;   // squeeze took the rate
      default:   state_d = PERM_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= PERM_IDLE;
      round_q <= '0;
      lfsr_q  <= '0;
      final_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (blk_fire) begin
        round_q <= round_t'(1);
        final_q <= blk_final;
      end else if (state_q == PERM_RUN) begin
        round_q <= round_q + 1'b1;
      end
      if (advance) lfsr_q <= lfsr_next;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) keccak_q <= round_out;
  end

endmodule

// File: design/shake_absorb.sv
`timescale 1ns/1ps

module shake_absorb (
  input  logic               clk,
  input  logic               arst_n,
  input  shake_pkg::word_t   in_data,
  input  shake_pkg::nbytes_t in_bytes,
  input  logic               in_last,
  input  logic               in_valid,
  output logic               in_ready,
  output shake_pkg::rate_t   blk_data,
  output shake_pkg::blk_op_e blk_op,
  output logic               blk_final,
  output logic               blk_valid,
  input  logic               blk_ready
);
  import shake_pkg::*;

  localparam word_idx_t LAST_IDX = word_idx_t'(RATE_WORDS - 1);

  absorb_state_e state_q;
  absorb_state_e state_d;
  rate_t         buf_q;
  rate_t         buf_d;
  word_idx_t     idx_q;
  word_t         tail_word;    // last word with unused bytes cleared and 0x1F behind the data
  logic          first_q;      // next block opens a message
  logic          final_q;
  logic          pad_pend_q;   // an all-padding block must follow
  logic          in_fire;
  logic          blk_fire;
  logic          blk_close;
  logic          tail_fits;

  assign in_fire   = in_valid && in_ready;
  assign blk_fire  = blk_valid && blk_ready;
  assign blk_close = in_last || (idx_q == LAST_IDX);
  assign tail_fits = !in_bytes[3] || (idx_q != LAST_IDX);
  assign tail_word = (in_data & ~({WORD_W{1'b1}} << (8 * in_bytes)))
                   | (word_t'(DOMAIN_PAD) << (8 * in_bytes));

  assign blk_data  = buf_q;
  assign blk_op    = first_q ? BLK_START : BLK_CONTINUE;
  assign blk_final = final_q;
  assign blk_valid = (state_q == ABS_SEND);

  ////////////////////////////////////////////////////////////////////////////
  // block buffer
  always_comb begin
    buf_d = buf_q;
    if (state_q == ABS_PAD_BLOCK) begin
      buf_d = '0;
      buf_d[WORD_W-1:0] = word_t'(DOMAIN_PAD);
      buf_d[RATE_W-1 -: WORD_W] = FINAL_PAD;
    end else if (in_fire) begin
      buf_d[idx_q*WORD_W +: WORD_W] = in_last ? tail_word : in_data;
      if (in_last) begin
        for (int w = 0; w < RATE_WORDS; w++) begin
          if (w == idx_q + 1 && in_bytes[3]) begin
            buf_d[w*WORD_W +: WORD_W] = word_t'(DOMAIN_PAD);  // full last word
          end else if (w > idx_q) begin
            buf_d[w*WORD_W +: WORD_W] = '0;
          end
        end
        if (tail_fits) buf_d[RATE_W-1 -: WORD_W] |= FINAL_PAD;
      end
    end
  end

  always_ff @(posedge clk) begin
    buf_q <= buf_d;
  end

  ////////////////////////////////////////////////////////////////////////////
  // control
  always_comb begin
    state_d = state_q;
    case (state_q)
      ABS_FILL:      if (in_fire && blk_close) state_d = ABS_SEND;
      ABS_SEND:      if (blk_fire) state_d = pad_pend_q ? ABS_PAD_BLOCK : ABS_FILL;
      ABS_PAD_BLOCK: state_d = ABS_SEND;
      default:       state_d = ABS_FILL;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q    <= ABS_FILL;
      idx_q      <= '0;
      first_q    <= 1'b1;
      final_q    <= 1'b0;
      pad_pend_q <= 1'b0;
      in_ready   <= 1'b0;
    end else begin
      state_q  <= state_d;
      in_ready <= (state_d == ABS_FILL);  // same as state_q == ABS_FILL one cycle on
      if (in_fire) begin
        idx_q <= blk_close ? '0 : idx_q + 1'b1;
        if (blk_close) begin
          final_q    <= in_last && tail_fits;
          pad_pend_q <= in_last && !tail_fits;
        end
      end
      if (blk_fire) first_q <= final_q;
      if (state_q == ABS_PAD_BLOCK) begin
        final_q    <= 1'b1;
        pad_pend_q <= 1'b0;
      end
    end
  end

endmodule

// File: design/shake_squeeze.sv
`timescale 1ns/1ps

module shake_squeeze #(
  parameter int OUT_WORDS = 4
) (
  input  logic             clk,
  input  logic             arst_n,
  input  shake_pkg::rate_t sq_data,
  input  logic             sq_valid,
  output logic             sq_ready,
  output shake_pkg::word_t out_data,
  output logic             out_last,
  output logic             out_valid,
  input  logic             out_ready
);
  import shake_pkg::*;

  localparam int OUT_W = OUT_WORDS * WORD_W;

  logic [OUT_W-1:0] data_q;   // words still to send, next one at the bottom
  word_idx_t        idx_q;
  logic             busy_q;
  logic             sq_fire;
  logic             out_fire;

  assign sq_ready  = !busy_q;
  assign sq_fire   = sq_valid && sq_ready;
  assign out_valid = busy_q;
  assign out_fire  = out_valid && out_ready;
  assign out_data  = data_q[WORD_W-1:0];
  assign out_last  = busy_q && (idx_q == word_idx_t'(OUT_WORDS - 1));

  // only the first OUT_WORDS rate words are kept
  always_ff @(posedge clk) begin
    if (sq_fire) begin
      data_q <= sq_data[OUT_W-1:0];
    end else if (out_fire) begin
      data_q <= data_q >> WORD_W;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else if (sq_fire) begin
      busy_q <= 1'b1;
      idx_q  <= '0;
    end else if (out_fire) begin
      busy_q <= !out_last;         // frees sq_ready once the last word is gone
      idx_q  <= idx_q + 1'b1;
    end
  end

endmodule

// File: design/shake128.sv
`timescale 1ns/1ps

module shake128 #(
  parameter int OUT_WORDS = 4
) (
  input  logic               clk,
  input  logic               arst_n,
  input  shake_pkg::word_t   in_data,
  input  shake_pkg::nbytes_t in_bytes,
  input  logic               in_last,
  input  logic               in_valid,
  output logic               in_ready,
  output shake_pkg::word_t   out_data,
  output logic               out_last,
  output logic               out_valid,
  input  logic               out_ready
);
  import shake_pkg::*;

  rate_t   blk_data;
  blk_op_e blk_op;
  logic    blk_final;
  logic    blk_valid;
  logic    blk_ready;
  rate_t   sq_data;
  logic    sq_valid;
  logic    sq_ready;

  shake_absorb i_absorb (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (in_data),
    .in_bytes  (in_bytes),
    .in_last   (in_last),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .blk_data  (blk_data),
    .blk_op    (blk_op),
    .blk_final (blk_final),
    .blk_valid (blk_valid),
    .blk_ready (blk_ready)
  );

  keccak_perm i_perm (
    .clk       (clk),
    .arst_n    (arst_n),
    .blk_data  (blk_data),
    .blk_op    (blk_op),
    .blk_final (blk_final),
    .blk_valid (blk_valid),
    .blk_ready (blk_ready),
    .sq_data   (sq_data),
    .sq_valid  (sq_valid),
    .sq_ready  (sq_ready)
  );

  shake_squeeze #(
    .OUT_WORDS (OUT_WORDS)
  ) i_squeeze (
    .clk       (clk),
    .arst_n    (arst_n),
    .sq_data   (sq_data),
    .sq_valid  (sq_valid),
    .sq_ready  (sq_ready),
    .out_data  (out_data),
    .out_last  (out_last),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

// File: include/shake128_model.svh
`ifndef SHAKE128_MODEL_SVH
`define SHAKE128_MODEL_SVH

// state bit 64*(5*y+x)+z as in FIPS 202
typedef bit model_state_t [1600];

function automatic int model_idx(input int x, input int y, input int z);
  return 64 * (5 * y + x) + z;
endfunction

// rc(t) straight from the lfsr definition
function automatic bit model_rc(input int t);
  bit [8:0] r;
  r = 9'h001;
  for (int i = 1; i <= t % 255; i++) begin
    r = r << 1;
    r[0] ^= r[8];
    r[4] ^= r[8];
    r[5] ^= r[8];
    r[6] ^= r[8];
    r[8] = 1'b0;
  end
  return r[0];
endfunction

function automatic void model_keccak_f(inout model_state_t s);
  model_state_t a;
  bit           c [5][64];
  int           x;
  int           y;
  int           nx;
  for (int ir = 0; ir < 24; ir++) begin
    for (int cx = 0; cx < 5; cx++) begin
      for (int z = 0; z < 64; z++) begin
        c[cx][z] = s[model_idx(cx, 0, z)] ^ s[model_idx(cx, 1, z)] ^ s[model_idx(cx, 2, z)]
                 ^ s[model_idx(cx, 3, z)] ^ s[model_idx(cx, 4, z)];
      end
    end
    for (int i = 0; i < 1600; i++) begin
      s[i] ^= c[((i / 64) % 5 + 4) % 5][i % 64] ^ c[((i / 64) % 5 + 1) % 5][(i % 64 + 63) % 64];
    end
    // rho walks the lanes from (1,0)
    a = s;
    x = 1;
    y = 0;
    for (int t = 0; t < 24; t++) begin
      for (int z = 0; z < 64; z++) begin
        a[model_idx(x, y, (z + (t + 1) * (t + 2) / 2) % 64)] = s[model_idx(x, y, z)];
      end
      nx = y;
      y  = (2 * x + 3 * y) % 5;
      x  = nx;
    end
    for (int i = 0; i < 1600; i++) begin
      s[i] = a[model_idx(((i / 64) % 5 + 3 * (i / 320)) % 5, (i / 64) % 5, i % 64)];
    end
    a = s;
    for (int i = 0; i < 1600; i++) begin
      s[i] = a[i] ^ (~a[model_idx(((i / 64) % 5 + 1) % 5, i / 320, i % 64)]
                     & a[model_idx(((i / 64) % 5 + 2) % 5, i / 320, i % 64)]);
    end
    for (int j = 0; j < 7; j++) begin
      s[(1 << j) - 1] ^= model_rc(j + 7 * ir);
    end
  end
endfunction

// SHAKE128 of msg, first n_words little-endian output words
function automatic void shake128_model(input byte unsigned msg [$], input int n_words,
                                       output logic [63:0] words [$]);
  byte unsigned p [$];
  model_state_t s;
  logic [63:0]  v;
  p = msg;
  p.push_back(8'h1F);
  while (p.size() % 168 != 0) begin
    p.push_back(8'h00);
  end
  p[p.size() - 1] |= 8'h80;   // may land on the 0x1F byte
  s = '{default: 1'b0};
  for (int b = 0; b < p.size() / 168; b++) begin
    for (int k = 0; k < 168 * 8; k++) begin
      s[k] ^= p[168 * b + k / 8][k % 8];
    end
    model_keccak_f(s);
  end
  words = {};
  for (int w = 0; w < n_words; w++) begin
    for (int i = 0; i < 64; i++) begin
      v[i] = s[64 * w + i];
    end
    words.push_back(v);
  end
endfunction

`endif

// File: tb/shake128_tb.sv
`timescale 1ns/1ps

`include "shake128_model.svh"

module shake128_tb;
  import shake_pkg::*;

  localparam int OUT_WORDS = 4;
  localparam int NUM_ROWS  = 16;

  logic    clk;
  logic    arst_n;
  word_t   in_data;
  nbytes_t in_bytes;
  logic    in_last;
  logic    in_valid;
  logic    in_ready;
  word_t   out_data;
  logic    out_last;
  logic    out_valid;
  logic    out_ready;

  // stimulus table, one entry per message
  string row_name  [NUM_ROWS];
  int    row_len   [NUM_ROWS];
  int    row_seed  [NUM_ROWS];
  int    row_stall [NUM_ROWS];   // percent of cycles with out_ready low
  int    row_kat   [NUM_ROWS];   // 0 model, 1 empty message, 2 "abc"
  int    row_off   [NUM_ROWS];   // first byte in msg_all
  int    n_rows;

  byte unsigned msg_all [$];
  word_t        exp_all [$];     // OUT_WORDS words per row
  int           seed;
  int           junk_seed;
  int           stall_seed;
  int           limit_cycles;
  int           word_errors;
  int           last_errors;
  int           other_errors;

  shake128 #(
    .OUT_WORDS (OUT_WORDS)
  ) i_shake128 (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (in_data),
    .in_bytes  (in_bytes),
    .in_last   (in_last),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_last  (out_last),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // table and expected values

  task automatic add_row(input string name, input int len, input int bseed,
                         input int stall, input int kat);
    row_name[n_rows]  = name;
    row_len[n_rows]   = len;
    row_seed[n_rows]  = bseed;
    row_stall[n_rows] = stall;
    row_kat[n_rows]   = kat;
    n_rows++;
  endtask

  // FIPS 202 SHAKE128 answers, bytes packed little-endian
  function automatic word_t kat_word(input int kat, input int w);
    word_t v;
    v = '0;
    if (kat == 1) begin
      case (w)
        0: v = 64'h7d828fe8a42b9c7f;
        1: v = 64'h3e85057650456061;
        2: v = 64'h88bceff693803bd7;
        3: v = 64'h26ef66faac6e1aeb;
        default: v = '0;
      endcase
    end else begin
      case (w)
        0: v = 64'h5cbf18d82d098158;
        1: v = 64'ha7cbfb93b7dda3f8;
        2: v = 64'h5fd3a626c5d59740;
        3: v = 64'hc82c0f945133b897;
        default: v = '0;
      endcase
    end
    return v;
  endfunction

  function automatic int num_words(input int len);
    return (len == 0) ? 1 : (len + 7) / 8;   // an empty message still sends one word
  endfunction

  task automatic build_rows();
    byte unsigned msg [$];
    word_t        words [$];
    int           sum;
    sum = 0;
    for (int r = 0; r < n_rows; r++) begin
      msg  = {};
      seed = 32'ha12 + row_seed[r];
      for (int i = 0; i < row_len[r]; i++) begin
        if (row_kat[r] == 2) msg.push_back(8'h61 + 8'(i));
        else msg.push_back(8'($random(seed)));
      end
      row_off[r] = msg_all.size();
      foreach (msg[i]) msg_all.push_back(msg[i]);
      if (row_kat[r] != 0) begin
        for (int w = 0; w < OUT_WORDS; w++) exp_all.push_back(kat_word(row_kat[r], w));
      end else begin
        shake128_model(msg, OUT_WORDS, words);
        for (int w = 0; w < OUT_WORDS; w++) exp_all.push_back(words[w]);
      end
      sum += num_words(row_len[r]) + (row_len[r] / 168 + 1) * 30 + OUT_WORDS * 4;
    end
    limit_cycles = 2 * sum;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // driver, monitor and compare tasks

  task automatic send_word(input word_t data, input nbytes_t nb, input logic last);
    logic taken;
    in_data  = data;
    in_bytes = nb;
    in_last  = last;
    in_valid = 1'b1;
    taken    = 1'b0;
    while (!taken) begin
      taken = in_ready;   // in_ready only moves on the rising edge
      @(negedge clk);
    end
  endtask

  task automatic drive_messages();
    word_t d;
    int    nw;
    int    pos;
    for (int r = 0; r < n_rows; r++) begin
      nw = num_words(row_len[r]);
      for (int w = 0; w < nw; w++) begin
        for (int k = 0; k < 8; k++) begin
          pos = 8 * w + k;
          if (pos < row_len[r]) d[8*k +: 8] = msg_all[row_off[r] + pos];
          else d[8*k +: 8] = 8'($random(junk_seed));   // junk the DUT has to mask
        end
        send_word(d, nbytes_t'((w == nw - 1) ? row_len[r] - 8 * (nw - 1) : 8), w == nw - 1);
      end
    end
    in_valid = 1'b0;
    in_last  = 1'b0;
  endtask

  task automatic check_word(input string name, input int idx, input word_t exp, input word_t act);
    if (act !== exp) begin
      word_errors++;
      $display("[FAIL] %s word %0d: expected %h, actual %h", name, idx, exp, act);
    end
  endtask

  task automatic check_last(input string name, input int idx, input logic exp, input logic act);
    if (act !== exp) begin
      last_errors++;
      $display("[FAIL] %s out_last on word %0d: expected %b, actual %b", name, idx, exp, act);
    end
  endtask

  task automatic collect_outputs();
    int   r;
    int   w;
    logic extra;
    r     = 0;
    w     = 0;
    extra = 1'b0;
    while (r < n_rows) begin
      @(negedge clk);
      out_ready = ($unsigned($random(stall_seed)) % 100) >= row_stall[r];
      if (out_valid && out_ready) begin   // word moves on the next rising edge
        check_word(row_name[r], w, exp_all[r*OUT_WORDS + w], out_data);
        check_last(row_name[r], w, w == OUT_WORDS - 1, out_last);
        w++;
        if (w == OUT_WORDS) begin
          w = 0;
          r++;
        end
      end
    end
    repeat (48) begin
      @(negedge clk);
      if (out_valid && !extra) begin
        other_errors++;
        extra = 1'b1;
        $display("an extra output word %h came after the last message", out_data);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    arst_n       = 1'b0;
    in_data      = '0;
    in_bytes     = '0;
    in_last      = 1'b0;
    in_valid     = 1'b0;
    out_ready    = 1'b0;
    n_rows       = 0;
    word_errors  = 0;
    last_errors  = 0;
    other_errors = 0;
    junk_seed    = 32'ha12;
    stall_seed   = 32'ha12;

    add_row("empty_kat", 0, 0, 0, 1);
    add_row("abc_kat", 3, 0, 0, 2);
    for (int n = 1; n <= 7; n++) add_row($sformatf("len_%0d", n), n, n, 0, 0);
    add_row("len_167", 167, 11, 0, 0);
    add_row("len_168", 168, 12, 0, 0);   // padding needs a block of its own
    add_row("len_400", 400, 13, 0, 0);
    add_row("len_1000", 1000, 14, 0, 0);
    add_row("stall_len_8", 8, 15, 50, 0);
    add_row("stall_len_200", 200, 16, 60, 0);
    add_row("stall_len_336", 336, 17, 40, 0);
    build_rows();

    fork
      begin
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the outputs did not arrive within %0d cycles", limit_cycles);
        $display("test failed");
        $finish;
      end
    join_none

    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    fork
      drive_messages();
      collect_outputs();
    join

    $display("errors: %0d word, %0d out_last, %0d other", word_errors, last_errors,
             other_errors);
    if (word_errors + last_errors + other_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: shake128.f
+incdir+include
design/keccak_pkg.sv
design/shake_pkg.sv
design/keccak_round.sv
design/keccak_perm.sv
design/shake_absorb.sv
design/shake_squeeze.sv
design/shake128.sv
tb/shake128_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the SHAKE128 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  -f shake128.f --top-module shake128_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vshake128_tb)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "test passed"; then
  exit 0
fi
exit 1
